// ==== nx_pkg.sv ====
/*
 * Shared types and constants for the outbound path of one mesh node
 * Every stream beat is a dir_msg_t, the direction travelling above the payload
 * The FIFO depth here is only a default and each FIFO instance may override it
 */

`default_nettype none

package nx_pkg;

    // Payload width of one message
    localparam int msg_width = 32;

    // Default FIFO depth and the pointer width it needs
    localparam int fifo_depth     = 4;
    localparam int fifo_ptr_width = $clog2(fifo_depth);

    // Output ports, one per compass direction
    localparam int num_dirs = 4;

    // Raw message payload, never decoded on this path
    typedef logic [msg_width-1:0] node_message_t;

    // Target direction, also the index of the output port
    typedef enum logic [1:0] {
        dir_north = 2'd0,
        dir_east  = 2'd1,
        dir_south = 2'd2,
        dir_west  = 2'd3
    } direction_t;

    // One beat on any stream of the node
    // Direction in the top two bits, payload below
    typedef struct packed {
        direction_t    dir;
        node_message_t data;
    } dir_msg_t;

    // Arbitration schemes of the stream combiner
    typedef enum logic [1:0] {
        arb_round_robin = 2'd0,
        arb_prefer_a    = 2'd1,
        arb_prefer_b    = 2'd2
    } arb_scheme_t;

endpackage : nx_pkg

`default_nettype wire

// ==== nx_msg_fifo.sv ====
/*
 * Valid/ready FIFO for one stream of direction-tagged messages
 * DEPTH must be 2 or more, it need not be a power of two
 * A beat written in cycle n shows on the output from cycle n+1
 * in_ready_o only reflects fullness, a read in the same cycle does not free a slot
 */

`timescale 1ns/1ps
`default_nettype none

module nx_msg_fifo #(
    parameter int DEPTH = nx_pkg::fifo_depth
) (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    // Write side
    input  wire nx_pkg::dir_msg_t in_data_i,
    input  wire logic             in_valid_i,
    output logic                  in_ready_o,
    // Read side
    output nx_pkg::dir_msg_t      out_data_o,
    output logic                  out_valid_o,
    input  wire logic             out_ready_i
);

    // Pointer width never narrower than the node default
    localparam int ptr_w = ($clog2(DEPTH) > nx_pkg::fifo_ptr_width) ?
                           $clog2(DEPTH) : nx_pkg::fifo_ptr_width;
    // Count has to reach DEPTH itself
    localparam int count_w = $clog2(DEPTH + 1);

    nx_pkg::dir_msg_t   mem_q [DEPTH];
    logic [ptr_w-1:0]   wr_ptr_q;
    logic [ptr_w-1:0]   rd_ptr_q;
    logic [count_w-1:0] count_q;
    logic               wr_en;
    logic               rd_en;

    // Flags straight from the occupancy count
    assign in_ready_o  = (count_q != count_w'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem_q[rd_ptr_q];

    // Transfers on each side
    assign wr_en = in_valid_i && in_ready_o;
    assign rd_en = out_valid_o && out_ready_i;

    // Storage
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

    // Pointers wrap at DEPTH, count tracks simultaneous read and write
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                if (wr_ptr_q == ptr_w'(DEPTH - 1)) wr_ptr_q <= '0;
                else                                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                if (rd_ptr_q == ptr_w'(DEPTH - 1)) rd_ptr_q <= '0;
                else                                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Occupancy stays within the buffer
    a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        count_q <= count_w'(DEPTH));

    // A full buffer keeps its write pointer, so no beat lands on it
    a_no_write_full: assert property (@(posedge clk_i) disable iff (rst_i)
        (count_q == count_w'(DEPTH)) |=> $stable(wr_ptr_q));

endmodule : nx_msg_fifo

`default_nettype wire

// ==== nx_stream_combiner.sv ====
/*
 * Two-to-one arbiter for direction-tagged streams with a registered output
 * The beat loaded comes from the stream chosen in the previous cycle
 * Only the selected stream sees ready, so an idle selection costs one cycle
 * ARB_SCHEME picks round robin, prefer A or prefer B
 */

`timescale 1ns/1ps
`default_nettype none

module nx_stream_combiner #(
    parameter nx_pkg::arb_scheme_t ARB_SCHEME = nx_pkg::arb_round_robin
) (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    // Stream A, passing traffic
    input  wire nx_pkg::dir_msg_t stream_a_i,
    input  wire logic             stream_a_valid_i,
    output logic                  stream_a_ready_o,
    // Stream B, locally generated traffic
    input  wire nx_pkg::dir_msg_t stream_b_i,
    input  wire logic             stream_b_valid_i,
    output logic                  stream_b_ready_o,
    // Arbitrated output
    output nx_pkg::dir_msg_t      comb_o,
    output logic                  comb_valid_o,
    input  wire logic             comb_ready_i
);

    // Selection encoding, 0 for A and 1 for B
    nx_pkg::dir_msg_t comb_q;
    logic             comb_valid_q;
    logic             curr_q;
    logic             next_q;

    logic             load;
    logic             curr_d;
    logic             next_d;
    logic             search_start;
    logic [1:0]       in_valid;

    assign comb_o       = comb_q;
    assign comb_valid_o = comb_valid_q;

    // Output register frees when empty or draining
    assign load = !comb_valid_q || comb_ready_i;

    // Stream taken this cycle is the one picked last cycle
    assign curr_d = load ? next_q : curr_q;

    assign stream_a_ready_o = load && (next_q == 1'b0);
    assign stream_b_ready_o = load && (next_q == 1'b1);

    assign in_valid = {stream_b_valid_i, stream_a_valid_i};

    // Next selection from the valids and the scheme
    always_comb begin
        case (ARB_SCHEME)
            nx_pkg::arb_prefer_a: search_start = 1'b0;
            nx_pkg::arb_prefer_b: search_start = 1'b1;
            // Round robin looks past the current stream first
            default:              search_start = ~curr_d;
        endcase

        // First valid stream wins, otherwise keep the old pick
        if (in_valid[search_start]) begin
            next_d = search_start;
        end else if (in_valid[~search_start]) begin
            next_d = ~search_start;
        end else begin
            next_d = next_q;
        end
    end

    // Control state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            comb_valid_q <= 1'b0;
            curr_q       <= 1'b0;
            next_q       <= 1'b0;
        end else begin
            if (load) begin
                comb_valid_q <= next_q ? stream_b_valid_i : stream_a_valid_i;
            end
            curr_q <= curr_d;
            next_q <= next_d;
        end
    end

    // Payload register
    always_ff @(posedge clk_i) begin
        if (load) begin
            comb_q <= next_q ? stream_b_i : stream_a_i;
        end
    end

    // A beat taken from stream A is the one presented next
    a_grant_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (stream_a_valid_i && stream_a_ready_o) |=>
        (comb_valid_o && comb_o == $past(stream_a_i)));

    // Same for stream B
    a_grant_b: assert property (@(posedge clk_i) disable iff (rst_i)
        (stream_b_valid_i && stream_b_ready_o) |=>
        (comb_valid_o && comb_o == $past(stream_b_i)));

    // Output beat held until taken
    a_comb_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        (comb_valid_o && !comb_ready_i) |=> (comb_valid_o && $stable(comb_o)));

endmodule : nx_stream_combiner

`default_nettype wire

// ==== nx_stream_distributor.sv ====
/*
 * Steers one direction-tagged stream into four per-direction output ports
 * Each port has its own holding register and back-pressure
 * A stalled port blocks the input for any beat heading the same way
 * Output ports carry the payload only, the port index gives the direction
 */

`timescale 1ns/1ps
`default_nettype none

module nx_stream_distributor (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_i,
    // Inbound stream
    input  wire nx_pkg::dir_msg_t                         in_i,
    input  wire logic                                     in_valid_i,
    output logic                                          in_ready_o,
    // Directional ports, indexed by direction_t
    output nx_pkg::node_message_t [nx_pkg::num_dirs-1:0]  out_data_o,
    output logic                  [nx_pkg::num_dirs-1:0]  out_valid_o,
    input  wire logic             [nx_pkg::num_dirs-1:0]  out_ready_i
);

    nx_pkg::node_message_t [nx_pkg::num_dirs-1:0] data_q;
    logic                  [nx_pkg::num_dirs-1:0] valid_q;
    logic                  [nx_pkg::num_dirs-1:0] load_sel;
    logic                                         accept;

    assign out_data_o  = data_q;
    assign out_valid_o = valid_q;

    // Target register free or draining this cycle
    assign in_ready_o = !valid_q[in_i.dir] || out_ready_i[in_i.dir];
    assign accept     = in_valid_i && in_ready_o;

    // One-hot decode of the accepted beat's direction
    always_comb begin
        load_sel = '0;
        if (accept) begin
            load_sel[in_i.dir] = 1'b1;
        end
    end

    // Per-port valid
    // A load wins over a drain in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            for (int d = 0; d < nx_pkg::num_dirs; d++) begin
                if (load_sel[d]) begin
                    valid_q[d] <= 1'b1;
                end else if (out_ready_i[d]) begin
                    valid_q[d] <= 1'b0;
                end
            end
        end
    end

    // Payload drops the direction field
    always_ff @(posedge clk_i) begin
        for (int d = 0; d < nx_pkg::num_dirs; d++) begin
            if (load_sel[d]) begin
                data_q[d] <= in_i.data;
            end
        end
    end

    // Each stalled port keeps its beat
    for (genvar g = 0; g < nx_pkg::num_dirs; g++) begin : g_port_chk
        a_port_stable: assert property (@(posedge clk_i) disable iff (rst_i)
            (out_valid_o[g] && !out_ready_i[g]) |=>
            (out_valid_o[g] && $stable(out_data_o[g])));
    end

endmodule : nx_stream_distributor

`default_nettype wire

// ==== nx_node_outbound.sv ====
/*
 * Outbound message path of one mesh node
 * Two FIFOs feed the combiner, the distributor fans out to N, E, S and W
 * Minimum latency is 3 cycles from input accept to port valid
 * Head-of-line blocking per direction back-pressures both inputs
 */

`timescale 1ns/1ps
`default_nettype none

module nx_node_outbound #(
    parameter nx_pkg::arb_scheme_t ARB_SCHEME = nx_pkg::arb_round_robin
) (
    input  wire logic                                     clk_i,
    input  wire logic                                     rst_i,
    // Passing traffic
    input  wire nx_pkg::dir_msg_t                         in_a_i,
    input  wire logic                                     in_a_valid_i,
    output logic                                          in_a_ready_o,
    // Locally generated traffic
    input  wire nx_pkg::dir_msg_t                         in_b_i,
    input  wire logic                                     in_b_valid_i,
    output logic                                          in_b_ready_o,
    // Directional output ports
    output nx_pkg::node_message_t [nx_pkg::num_dirs-1:0]  out_data_o,
    output logic                  [nx_pkg::num_dirs-1:0]  out_valid_o,
    input  wire logic             [nx_pkg::num_dirs-1:0]  out_ready_i
);

    // Buffered streams
    nx_pkg::dir_msg_t buf_a;
    logic             buf_a_valid;
    logic             buf_a_ready;
    nx_pkg::dir_msg_t buf_b;
    logic             buf_b_valid;
    logic             buf_b_ready;

    // Arbitrated stream
    nx_pkg::dir_msg_t comb;
    logic             comb_valid;
    logic             comb_ready;

    // Stream A buffer
    nx_msg_fifo #(
        .DEPTH(nx_pkg::fifo_depth)
    ) u_fifo_a (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_data_i  (in_a_i),
        .in_valid_i (in_a_valid_i),
        .in_ready_o (in_a_ready_o),
        .out_data_o (buf_a),
        .out_valid_o(buf_a_valid),
        .out_ready_i(buf_a_ready)
    );

    // Stream B buffer
    nx_msg_fifo #(
        .DEPTH(nx_pkg::fifo_depth)
    ) u_fifo_b (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_data_i  (in_b_i),
        .in_valid_i (in_b_valid_i),
        .in_ready_o (in_b_ready_o),
        .out_data_o (buf_b),
        .out_valid_o(buf_b_valid),
        .out_ready_i(buf_b_ready)
    );

    // Arbitration between the two buffers
    nx_stream_combiner #(
        .ARB_SCHEME(ARB_SCHEME)
    ) u_comb (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stream_a_i      (buf_a),
        .stream_a_valid_i(buf_a_valid),
        .stream_a_ready_o(buf_a_ready),
        .stream_b_i      (buf_b),
        .stream_b_valid_i(buf_b_valid),
        .stream_b_ready_o(buf_b_ready),
        .comb_o          (comb),
        .comb_valid_o    (comb_valid),
        .comb_ready_i    (comb_ready)
    );

    // Fan-out to the directional ports
    nx_stream_distributor u_dist (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_i       (comb),
        .in_valid_i (comb_valid),
        .in_ready_o (comb_ready),
        .out_data_o (out_data_o),
        .out_valid_o(out_valid_o),
        .out_ready_i(out_ready_i)
    );

endmodule : nx_node_outbound

`default_nettype wire

// ==== tb_nx_node_outbound.sv ====
/*
 * Self-checking testbench for the outbound path of one mesh node
 * Inputs and port readies change on the falling clock edge
 * Payload bit 31 names the source and bits 15:0 carry its sequence number
 * The direction of a beat is a keyed function of source and sequence number
 */

`timescale 1ns/1ps
`default_nettype none

module tb_nx_node_outbound;

    localparam int total_beats    = 200 + 2 * 300 + 2 * 100;
    localparam int timeout_cycles = total_beats * 40 + 2000;
    localparam int sb_slots       = 1024;

    logic                                         clk_i;
    logic                                         rst_i;
    nx_pkg::dir_msg_t                             in_a_i;
    logic                                         in_a_valid_i;
    logic                                         in_a_ready_o;
    nx_pkg::dir_msg_t                             in_b_i;
    logic                                         in_b_valid_i;
    logic                                         in_b_ready_o;
    nx_pkg::node_message_t [nx_pkg::num_dirs-1:0] out_data_o;
    logic                  [nx_pkg::num_dirs-1:0] out_valid_o;
    logic                  [nx_pkg::num_dirs-1:0] out_ready_i;

    // Random streams: 0 and 1 for input gaps, 2 for port readies
    logic [31:0] rng_state [3];
    // Scoreboard, one circular queue of sequence numbers per source and direction
    logic [15:0] sb_mem [8][sb_slots];
    int          sb_head [8];
    int          sb_tail [8];
    logic [15:0] seq_cnt [2];
    int          phase_cnt [2];
    logic        rand_ready;
    logic        fair_phase;
    int          errors;
    int          test_err_start;
    int          tests_passed;
    int          tests_failed;

    nx_node_outbound #(
        .ARB_SCHEME(nx_pkg::arb_round_robin)
    ) dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_a_i      (in_a_i),
        .in_a_valid_i(in_a_valid_i),
        .in_a_ready_o(in_a_ready_o),
        .in_b_i      (in_b_i),
        .in_b_valid_i(in_b_valid_i),
        .in_b_ready_o(in_b_ready_o),
        .out_data_o  (out_data_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand(input int k);
        rng_state[k] = lcg(rng_state[k]);
        return rng_state[k];
    endfunction

    // Direction from a second LCG stream keyed by source and sequence number
    function automatic nx_pkg::direction_t dir_for(input logic src, input logic [15:0] seq);
        logic [31:0] s;
        s = 32'h2267 ^ {src, 15'd0, seq};
        s = lcg(lcg(lcg(s)));
        return nx_pkg::direction_t'(s[31:30]);
    endfunction

    // Expected beat for a source and sequence number
    function automatic nx_pkg::dir_msg_t ref_beat(input logic src, input logic [15:0] seq);
        nx_pkg::dir_msg_t b;
        b.dir  = dir_for(src, seq);
        b.data = {src, 15'd0, seq};
        return b;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) n += sb_tail[i] - sb_head[i];
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        if (expected !== got) begin
            $display("error %s expected %h got %h", name, expected, got);
            errors++;
        end
    endtask

    task automatic set_input(input logic src, input logic valid, input nx_pkg::dir_msg_t beat);
        if (src == 1'b0) begin
            in_a_valid_i = valid;
            in_a_i       = beat;
        end else begin
            in_b_valid_i = valid;
            in_b_i       = beat;
        end
    endtask

    // Offers count beats on one source, held until accepted
    task automatic send_beats(input logic src, input int count, input logic gaps);
        int               sent;
        logic [31:0]      r;
        nx_pkg::dir_msg_t beat;
        sent = 0;
        while (sent < count) begin
            @(negedge clk_i);
            r = next_rand(src);
            if (gaps && r[31:30] == 2'b00) begin
                set_input(src, 1'b0, '0);
            end else begin
                beat = ref_beat(src, seq_cnt[src]);
                set_input(src, 1'b1, beat);
                // FIFO ready depends only on its fill level
                while (!(src ? in_b_ready_o : in_a_ready_o)) @(negedge clk_i);
                sb_mem[src*4 + beat.dir][sb_tail[src*4 + beat.dir] % sb_slots] = seq_cnt[src];
                sb_tail[src*4 + beat.dir]++;
                seq_cnt[src]++;
                sent++;
            end
        end
        @(negedge clk_i);
        set_input(src, 1'b0, '0);
    endtask

    // Waits for the scoreboard to empty, then lets stray beats show up
    task automatic drain(input int max_cycles);
        int c;
        c = 0;
        rand_ready = 1'b0;
        while (pending() != 0 && c < max_cycles) begin
            @(negedge clk_i);
            c++;
        end
        if (pending() != 0) begin
            $display("scoreboard still holds %0d beats after the drain period", pending());
            errors++;
        end
        repeat (10) @(negedge clk_i);
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - test_err_start;
        if (n == 0) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, n);
        end
        test_err_start = errors;
    endtask

    // One delivered beat on port p against the scoreboard
    task automatic check_output(input int p);
        logic             src;
        int               idx;
        int               diff;
        nx_pkg::dir_msg_t exp;
        src = out_data_o[p][31];
        idx = src * 4 + p;
        if (sb_head[idx] == sb_tail[idx]) begin
            $display("unexpected beat %h on port %0d", out_data_o[p], p);
            errors++;
        end else begin
            exp = ref_beat(src, sb_mem[idx][sb_head[idx] % sb_slots]);
            sb_head[idx]++;
            check_value("out_data_o", exp.data, out_data_o[p]);
        end
        phase_cnt[src]++;
        if (fair_phase) begin
            diff = phase_cnt[0] - phase_cnt[1];
            if (diff < 0) diff = -diff;
            if (diff > nx_pkg::fifo_depth + 3) begin
                $display("round robin imbalance, A delivered %0d and B delivered %0d",
                         phase_cnt[0], phase_cnt[1]);
                errors++;
            end
        end
    endtask

    // Port side: drives readies, takes beats, checks stalled ports hold
    initial begin : port_monitor
        logic [31:0]           r;
        logic [3:0]            ready;
        logic [3:0]            stalled;
        nx_pkg::node_message_t held [4];
        stalled = '0;
        forever begin
            @(negedge clk_i);
            for (int p = 0; p < nx_pkg::num_dirs; p++) begin
                if (stalled[p]) begin
                    check_value("out_valid_o", 32'd1, 32'(out_valid_o[p]));
                    check_value("out_data_o", held[p], out_data_o[p]);
                end
            end
            r           = next_rand(2);
            ready       = rand_ready ? r[31:28] : 4'hf;
            out_ready_i = ready;
            for (int p = 0; p < nx_pkg::num_dirs; p++) begin
                if (!rst_i && out_valid_o[p] && ready[p]) check_output(p);
                stalled[p] = !rst_i && out_valid_o[p] && !ready[p];
                held[p]    = out_data_o[p];
            end
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk_i);
        $display("run timed out after %0d cycles", timeout_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_i        = 1'b1;
        in_a_i       = '0;
        in_a_valid_i = 1'b0;
        in_b_i       = '0;
        in_b_valid_i = 1'b0;
        out_ready_i  = '1;
        rand_ready   = 1'b0;
        fair_phase   = 1'b0;
        errors       = 0;
        test_err_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        seq_cnt      = '{16'd0, 16'd0};
        phase_cnt    = '{0, 0};
        for (int k = 0; k < 3; k++) rng_state[k] = lcg(32'h2267 + k);
        for (int i = 0; i < 8; i++) begin
            sb_head[i] = 0;
            sb_tail[i] = 0;
        end
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Idle state after reset
        @(negedge clk_i);
        check_value("out_valid_o", 32'd0, 32'(out_valid_o));
        check_value("in_a_ready_o", 32'd1, 32'(in_a_ready_o));
        check_value("in_b_ready_o", 32'd1, 32'(in_b_ready_o));
        finish_test("reset");

        send_beats(1'b0, 200, 1'b0);
        drain(2000);
        finish_test("stream A routing");

        // Random gaps and port back-pressure on both sources
        rand_ready = 1'b1;
        fork
            send_beats(1'b0, 300, 1'b1);
            send_beats(1'b1, 300, 1'b1);
        join
        drain(4000);
        finish_test("mixed traffic under back-pressure");

        // Both inputs held valid, every port ready
        phase_cnt  = '{0, 0};
        fair_phase = 1'b1;
        fork
            send_beats(1'b0, 100, 1'b0);
            send_beats(1'b1, 100, 1'b0);
        join
        drain(2000);
        fair_phase = 1'b0;
        check_value("delivered A", 32'd100, 32'(phase_cnt[0]));
        check_value("delivered B", 32'd100, 32'(phase_cnt[1]));
        finish_test("round robin fairness");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_nx_node_outbound

`default_nettype wire

// ==== build.f ====
nx_pkg.sv
nx_msg_fifo.sv
nx_stream_combiner.sv
nx_stream_distributor.sv
nx_node_outbound.sv
tb_nx_node_outbound.sv
